//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - files:
      - cache_pkg.sv
      - mem_bus_if.sv
      - sp_ram_be.sv
      - write_through_buffer.sv
      - cache_back_end.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: simulation
    files:
      - tb_cache_top.sv

//--- cache_back_end.sv
`timescale 1ns/1ns
`default_nettype none

module cache_back_end (
   mem_bus_if.slave  wtb,
   mem_bus_if.slave  fill,
   mem_bus_if.master ram
);

   logic sel_fill;

   // fills only start with the buffer drained, so no arbitration is needed
   assign sel_fill = fill.req;

   always_comb begin
      if (sel_fill) begin
         ram.req = fill.req;
         ram.addr = fill.addr;
         ram.wdata = fill.wdata;
         ram.wstrb = fill.wstrb;
      end else begin
         ram.req = wtb.req;
         ram.addr = wtb.addr;
         ram.wdata = wtb.wdata;
         ram.wstrb = wtb.wstrb;
      end
   end

   // ack back to whoever owns the bus
   always_comb begin
      fill.ack = ram.ack & sel_fill;
      wtb.ack = ram.ack & ~sel_fill;
   end

   // read data to both, only the fill side looks at it
   always_comb begin
      fill.rdata = ram.rdata;
      wtb.rdata = ram.rdata;
   end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          req,
   input  logic [cache_pkg::addr_w-1:0]  addr,
   input  logic [cache_pkg::data_w-1:0]  wdata,
   input  logic [cache_pkg::n_bytes-1:0] wstrb,
   output logic [cache_pkg::data_w-1:0]  rdata,
   output logic                          ack,
   input  logic                          invalidate,
   output logic                          wtb_push,
   output cache_pkg::wtb_entry_t         wtb_entry,
   input  logic                          wtb_full,
   input  logic                          wtb_empty,
   mem_bus_if.master                     fill
);
   import cache_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_wait_empty,
      s_fill,
      s_respond
   } state_t;

   state_t state;

   logic [tag_w-1:0]              req_tag;
   logic [line_w-1:0]             req_line;
   logic [word_off_w-1:0]         req_off;
   logic [line_w+word_off_w-1:0]  word_idx;

   logic [2**line_w-1:0] valid;
   logic [tag_w-1:0]     tag_mem [2**line_w];
   logic [data_w-1:0]    data_mem [2**(line_w+word_off_w)];

   logic [word_off_w-1:0] fill_off;
   logic                  fill_last;
   logic                  hit;
   logic                  is_write;
   logic                  accept;
   logic                  do_inval;

   // host holds addr stable until ack, so it is used directly
   assign req_tag = addr[addr_w-1 -: tag_w];
   assign req_line = addr[word_off_w +: line_w];
   assign req_off = addr[word_off_w-1:0];
   assign word_idx = {req_line, req_off};

   assign hit = valid[req_line] && (tag_mem[req_line] == req_tag);
   assign is_write = |wstrb;

   // invalidate wins over a request in the same cycle
   assign do_inval = invalidate && (state == s_idle);
   // skip the ack cycle, req is still up there
   assign accept = (state == s_idle) && req && !ack && !invalidate;

   assign fill_last = (fill_off == '1);

   // every write goes to the buffer, hit or not
   assign wtb_push = accept && is_write && !wtb_full;

   always_comb begin
      wtb_entry.addr = addr;
      wtb_entry.data = wdata;
      wtb_entry.strb = wstrb;
   end

   // line fill, one word per back-end read
   always_comb begin
      fill.req = (state == s_fill);
      fill.addr = {req_tag, req_line, fill_off};
      fill.wdata = '0;
      fill.wstrb = '0;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= s_idle;
         ack <= 1'b0;
         valid <= '0;
         fill_off <= '0;
      end else begin
         ack <= 1'b0;
         case (state)
            s_idle: begin
               if (do_inval) begin
                  valid <= '0;
               end else if (accept) begin
                  if (is_write) begin
                     // full buffer: stay here and retry
                     ack <= !wtb_full;
                  end else if (hit) begin
                     ack <= 1'b1;
                  end else begin
                     state <= s_wait_empty;
                  end
               end
            end
            s_wait_empty: begin
               // memory must be up to date before the fill
               if (wtb_empty) begin
                  fill_off <= '0;
                  state <= s_fill;
               end
            end
            s_fill: begin
               if (fill.ack) begin
                  fill_off <= fill_off + 1'b1;
                  if (fill_last) begin
                     valid[req_line] <= 1'b1;
                     state <= s_respond;
                  end
               end
            end
            s_respond: begin
               ack <= 1'b1;
               state <= s_idle;
            end
            default: state <= s_idle;
         endcase
      end
   end

   // tag and data arrays
   always_ff @(posedge clk) begin
      if (wtb_push && hit) begin
         for (int i = 0; i < n_bytes; i++) begin
            if (wstrb[i]) begin
               data_mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
      if (accept && !is_write && hit) begin
         rdata <= data_mem[word_idx];
      end
      if ((state == s_fill) && fill.ack) begin
         data_mem[{req_line, fill_off}] <= fill.rdata;
         if (fill_last) begin
            tag_mem[req_line] <= req_tag;
         end
      end
      if (state == s_respond) begin
         rdata <= data_mem[word_idx];
      end
   end

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

   // data word and byte lanes
   localparam int data_w = 32;
   localparam int n_bytes = 4;

   // word address, shared by host and back-end
   localparam int addr_w = 10;

   // address split: tag | line | word offset
   localparam int word_off_w = 2;
   localparam int line_w = 4;
   localparam int tag_w = addr_w - line_w - word_off_w;

   // write buffer holds 2**wtb_depth_w entries
   localparam int wtb_depth_w = 2;

   // one pending write on its way to the back-end
   typedef struct packed {
      logic [addr_w-1:0]  addr;
      logic [data_w-1:0]  data;
      logic [n_bytes-1:0] strb;
   } wtb_entry_t;

endpackage

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          req,
   input  logic [cache_pkg::addr_w-1:0]  addr,
   input  logic [cache_pkg::data_w-1:0]  wdata,
   input  logic [cache_pkg::n_bytes-1:0] wstrb,
   output logic [cache_pkg::data_w-1:0]  rdata,
   output logic                          ack,
   input  logic                          invalidate,
   output logic                          wtb_empty
);
   import cache_pkg::*;

   logic       wtb_push;
   wtb_entry_t wtb_entry;
   logic       wtb_full;

   mem_bus_if wtb_bus ();
   mem_bus_if fill_bus ();
   mem_bus_if ram_bus ();

   cache_ctrl cache_ctrl_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .invalidate (invalidate),
      .wtb_push   (wtb_push),
      .wtb_entry  (wtb_entry),
      .wtb_full   (wtb_full),
      .wtb_empty  (wtb_empty),
      .fill       (fill_bus.master)
   );

   write_through_buffer write_through_buffer_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (wtb_push),
      .push_entry (wtb_entry),
      .full       (wtb_full),
      .empty      (wtb_empty),
      .bus        (wtb_bus.master)
   );

   // drains and fills share the one RAM port
   cache_back_end cache_back_end_i (
      .wtb  (wtb_bus.slave),
      .fill (fill_bus.slave),
      .ram  (ram_bus.master)
   );

   sp_ram_be sp_ram_be_i (
      .clk (clk),
      .bus (ram_bus.slave)
   );

endmodule

`default_nettype wire

//--- mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if;
   import cache_pkg::*;

   logic               req;
   logic [addr_w-1:0]  addr;
   logic [data_w-1:0]  wdata;
   logic [n_bytes-1:0] wstrb;
   logic [data_w-1:0]  rdata;
   logic               ack;

   // request side
   modport master (
      output req, addr, wdata, wstrb,
      input  rdata, ack
   );

   // memory side
   modport slave (
      input  req, addr, wdata, wstrb,
      output rdata, ack
   );

endinterface

`default_nettype wire

//--- sp_ram_be.sv
`timescale 1ns/1ns
`default_nettype none

module sp_ram_be (
   input logic      clk,
   mem_bus_if.slave bus
);
   import cache_pkg::*;

   logic [data_w-1:0] mem [2**addr_w];
   logic              access;

   // one access per request, the ack cycle is not a new one
   assign access = bus.req & ~bus.ack;

   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < n_bytes; i++) begin
            if (bus.wstrb[i]) begin
               mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
         end
         bus.rdata <= mem[bus.addr];
      end
   end

   // ack is the registered request, high for a single cycle
   always_ff @(posedge clk) begin
      bus.ack <= access;
   end

endmodule

`default_nettype wire

//--- tb_cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_top;
   import cache_pkg::*;

   localparam logic [addr_w-1:0] region_base = 10'h0c0;
   // same line indices as the region with another tag
   localparam logic [addr_w-1:0] far_base = 10'h3c0;
   localparam int n_region = 64;
   localparam int n_random = 200;
   localparam int n_strobe = 16;
   localparam int n_lines = 16;
   localparam int n_burst = 8;
   localparam int n_tests = n_region + n_random + 6*n_strobe + 3*n_lines + 2*n_burst;
   localparam int worst_cycles = 40;

   logic               clk;
   logic               arst_n;
   logic               req;
   logic [addr_w-1:0]  addr;
   logic [data_w-1:0]  wdata;
   logic [n_bytes-1:0] wstrb;
   logic [data_w-1:0]  rdata;
   logic               ack;
   logic               invalidate;
   logic               wtb_empty;

   logic [7:0]        shadow [2**addr_w][n_bytes];
   logic [addr_w-1:0] burst_addr [n_burst];
   logic              expect_hit;
   integer            seed;

   cache_top cache_top_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .invalidate (invalidate),
      .wtb_empty  (wtb_empty)
   );

   always #10 clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [data_w-1:0] expected_word(input logic [addr_w-1:0] a);
      logic [data_w-1:0] w;
      for (int i = 0; i < n_bytes; i++) begin
         w[8*i +: 8] = shadow[a][i];
      end
      return w;
   endfunction

   // one host request until ack is seen on a falling edge
   task automatic host_access(
      input  logic [addr_w-1:0]  a,
      input  logic [data_w-1:0]  d,
      input  logic [n_bytes-1:0] s,
      input  logic               hit_expected,
      output logic [data_w-1:0]  rd,
      output int                 cycles
   );
      @(negedge clk);
      req = 1'b1;
      addr = a;
      wdata = d;
      wstrb = s;
      expect_hit = hit_expected;
      @(negedge clk);
      cycles = 1;
      while (!ack) begin
         @(negedge clk);
         cycles++;
      end
      rd = rdata;
      req = 1'b0;
      wstrb = '0;
      expect_hit = 1'b0;
   endtask

   task automatic write_word(
      input logic [addr_w-1:0]  a,
      input logic [data_w-1:0]  d,
      input logic [n_bytes-1:0] s
   );
      logic [data_w-1:0] rd;
      int                cycles;
      host_access(a, d, s, 1'b0, rd, cycles);
      for (int i = 0; i < n_bytes; i++) begin
         if (s[i]) begin
            shadow[a][i] = d[8*i +: 8];
         end
      end
   endtask

   task automatic read_check(
      input  string             name,
      input  logic [addr_w-1:0] a,
      input  logic              hit_expected,
      output int                cycles
   );
      logic [data_w-1:0] rd;
      logic [data_w-1:0] exp;
      host_access(a, '0, '0, hit_expected, rd, cycles);
      exp = expected_word(a);
      assert (rd === exp)
         else stop_on_error($sformatf("Error: %s addr %h expected %h actual %h",
                                      name, a, exp, rd));
   endtask

   // a request sampled on a hit line is acked on the very next edge
   assert property (@(posedge clk) disable iff (!arst_n)
      (expect_hit && req && !ack) |=> ack)
      else stop_on_error("Error: hit_latency expected ack 1 actual ack 0");

   assert property (@(negedge clk) disable iff (!arst_n) ack |=> !ack)
      else stop_on_error("ack stayed high for two cycles in a row");

   assert property (@(negedge clk) disable iff (!arst_n) ack |-> req)
      else stop_on_error("ack was high while req was low");

   initial begin
      repeat (n_tests * worst_cycles + 10) @(posedge clk);
      stop_on_error("timeout, the tests did not finish in the expected time");
   end

   initial begin
      logic [data_w-1:0]  r;
      logic [data_w-1:0]  d;
      logic [addr_w-1:0]  a;
      logic [n_bytes-1:0] s;
      int                 cycles;
      int                 wait_cycles;
      seed = 32'h0603b658;
      clk = 1'b0;
      arst_n = 1'b0;
      req = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      invalidate = 1'b0;
      expect_hit = 1'b0;
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      assert (ack === 1'b0)
         else stop_on_error($sformatf("Error: reset ack expected 0 actual %b", ack));
      assert (wtb_empty === 1'b1)
         else stop_on_error($sformatf("Error: reset wtb_empty expected 1 actual %b",
                                      wtb_empty));

      // whole region gets known contents first
      for (int i = 0; i < n_region; i++) begin
         r = $random(seed);
         write_word(region_base + addr_w'(i), r, 4'hf);
      end

      for (int n = 0; n < n_random; n++) begin
         r = $random(seed);
         a = region_base + addr_w'(r[5:0]);
         if (r[6]) begin
            d = $random(seed);
            write_word(a, d, 4'hf);
         end else begin
            read_check("random", a, 1'b0, cycles);
         end
      end

      // partial writes on a cached line
      for (int i = 0; i < n_strobe; i++) begin
         r = $random(seed);
         a = region_base + addr_w'(r[5:0]);
         read_check("strobe_hit_pre", a, 1'b0, cycles);
         s = r[9:6];
         if ((s == '0) || (s == '1)) begin
            s = 4'b0010;
         end
         d = $random(seed);
         write_word(a, d, s);
         read_check("strobe_hit", a, 1'b1, cycles);
      end

      // partial writes on lines that were never read
      for (int i = 0; i < n_strobe; i++) begin
         r = $random(seed);
         a = far_base + addr_w'(4 * i) + addr_w'(r[1:0]);
         d = $random(seed);
         write_word(a, d, 4'hf);
         s = r[5:2];
         if ((s == '0) || (s == '1)) begin
            s = 4'b1000;
         end
         d = $random(seed);
         write_word(a, d, s);
         read_check("strobe_miss", a, 1'b0, cycles);
      end

      for (int l = 0; l < n_lines; l++) begin
         a = region_base + addr_w'(4 * l);
         read_check("inval_prep", a, 1'b0, cycles);
         read_check("hit_latency", a + 1'b1, 1'b1, cycles);
      end
      @(negedge clk);
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
      for (int l = 0; l < n_lines; l++) begin
         a = region_base + addr_w'(4 * l);
         read_check("inval_read", a, 1'b0, cycles);
         assert (cycles > 1)
            else stop_on_error($sformatf("Error: inval_latency addr %h expected >1 actual %0d",
                                         a, cycles));
      end

      for (int i = 0; i < n_burst; i++) begin
         r = $random(seed);
         burst_addr[i] = region_base + addr_w'(r[5:0]);
         d = $random(seed);
         write_word(burst_addr[i], d, 4'hf);
      end
      assert (wtb_empty === 1'b0)
         else stop_on_error($sformatf("Error: burst wtb_empty expected 0 actual %b",
                                      wtb_empty));
      wait_cycles = 0;
      while (!wtb_empty) begin
         @(negedge clk);
         wait_cycles++;
         if (wait_cycles > worst_cycles) begin
            stop_on_error("write buffer never drained after the burst");
         end
      end
      for (int i = 0; i < n_burst; i++) begin
         read_check("burst", burst_addr[i], 1'b0, cycles);
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
cache_pkg.sv
mem_bus_if.sv
sp_ram_be.sv
write_through_buffer.sv
cache_back_end.sv
cache_ctrl.sv
cache_top.sv
tb_cache_top.sv

//--- write_through_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module write_through_buffer (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 push,
   input  cache_pkg::wtb_entry_t push_entry,
   output logic                 full,
   output logic                 empty,
   mem_bus_if.master            bus
);
   import cache_pkg::*;

   wtb_entry_t             fifo [2**wtb_depth_w];
   logic [wtb_depth_w-1:0] wr_ptr;
   logic [wtb_depth_w-1:0] rd_ptr;
   logic [wtb_depth_w:0]   count;
   logic                   do_push;
   logic                   do_pop;
   wtb_entry_t             head;

   assign full = count[wtb_depth_w];
   // an entry stays counted until its drain is acked
   assign empty = (count == '0);

   assign do_push = push & ~full;
   assign do_pop = bus.ack;

   always_ff @(posedge clk) begin
      if (do_push) begin
         fifo[wr_ptr] <= push_entry;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head entry goes out as a write while anything is pending
   assign head = fifo[rd_ptr];

   always_comb begin
      bus.req = ~empty;
      bus.addr = head.addr;
      bus.wdata = head.data;
      bus.wstrb = head.strb;
   end

endmodule

`default_nettype wire
